// ==== obj_config.svh ====
// sizes and limits shared by the object engine RTL.
// include where a module needs table, line or window sizes.
`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

// object table entries, four words each.
`define OBJ_TABLE_DEPTH 32

// pixels per line buffer half.
`define OBJ_LINE_W 512

// tile height in lines.
`define OBJ_TILE_H 16

// visible x window, both limits exclusive.
`define OBJ_X_MIN 9'h030
`define OBJ_X_MAX 9'h1c0

`define OBJ_BLANK_PIXEL 9'h1ff  // value of a cleared entry.

`endif

// ==== obj_video_pkg.sv ====
// video-side types of the object engine: sprite words, pixels and FSM states.
`default_nettype none

package obj_video_pkg;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_FETCH,  // waiting on a graphics word.
        DRAW_PAINT
    } obj_draw_state_t;

    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_READ,
        SCAN_TEST,
        SCAN_ISSUE,
        SCAN_WAIT_DRAW
    } obj_scan_state_t;

    // line buffer pixel. colour 15 is transparent.
    typedef struct packed {
        logic [4:0] pal;
        logic [3:0] colour;
    } obj_pixel_t;

    typedef struct packed {
        logic [3:0] rsvd_hi;
        logic [3:0] row;     // tile row, filled in by the scanner.
        logic       rsvd_lo;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } obj_attr_t;

    // last word of a table entry.
    typedef struct packed {
        logic [13:0] rsvd_hi;
        logic [1:0]  bank;
        logic [6:0]  rsvd_lo;
        logic [8:0]  ypos;
    } obj_ypos_bank_t;

endpackage

`default_nettype wire

// ==== obj_host_pkg.sv ====
// host register map and register layouts of the object engine.
// offsets are word addresses, taken from paddr[11:2].
`default_nettype none

package obj_host_pkg;

    typedef enum logic [9:0] {
        REG_CTRL   = 10'h000,
        REG_STATUS = 10'h001,  // read only.
        REG_TABLE  = 10'h080   // first word of the object table.
    } obj_reg_t;

    // word order inside one table entry.
    typedef enum logic [1:0] {
        FIELD_CODE      = 2'd0,
        FIELD_ATTR      = 2'd1,
        FIELD_XPOS      = 2'd2,
        FIELD_YPOS_BANK = 2'd3
    } obj_entry_field_t;

    typedef struct packed {
        logic [6:0]  rsvd_hi;
        logic [8:0]  line;     // bits 24:16.
        logic [14:0] rsvd_lo;
        logic        enable;
    } obj_ctrl_t;

    typedef struct packed {
        logic [17:0] rsvd_hi;
        logic [5:0]  count;    // sprites issued, bits 13:8.
        logic [6:0]  rsvd_lo;
        logic        busy;
    } obj_status_t;

endpackage

`default_nettype wire

// ==== obj_host_regs.sv ====
// APB slave with the object table memory, the control register and live status.
// the scanner reads the table through a synchronous port.
`timescale 1ns/100ps
`default_nettype none
`include "obj_config.svh"

module obj_host_regs
    import obj_host_pkg::*;
(
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire  [11:0]                          paddr,
    input  wire  [31:0]                          pwdata,
    output logic [31:0]                          prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  wire  [$clog2(`OBJ_TABLE_DEPTH)-1:0]  tbl_index,
    input  wire  obj_entry_field_t               tbl_field,
    output logic [31:0]                          tbl_word,
    output logic                                 ctrl_enable,
    output logic [8:0]                           ctrl_line,
    input  wire                                  scan_busy,
    input  wire  [5:0]                           issue_count
);

    localparam int IDX_W     = $clog2(`OBJ_TABLE_DEPTH);
    localparam int TBL_WORDS = 4 * `OBJ_TABLE_DEPTH;

    logic [31:0]      table_mem [TBL_WORDS];
    logic [9:0]       word_addr;
    logic [IDX_W+1:0] tbl_addr;
    logic             hit_ctrl, hit_status, hit_table;
    logic             access, wr_en;
    obj_ctrl_t        ctrl_q;
    obj_status_t      status;

    assign word_addr  = paddr[11:2];
    assign hit_ctrl   = word_addr == REG_CTRL;
    assign hit_status = word_addr == REG_STATUS;
    assign hit_table  = word_addr >= REG_TABLE && word_addr < REG_TABLE + TBL_WORDS;
    assign access     = psel && penable;
    assign wr_en      = access && pwrite;
    assign tbl_addr   = {tbl_index, tbl_field};

    assign pready  = 1'b1;  // zero wait states.
    assign pslverr = access && !(hit_ctrl || hit_status || hit_table);

    // scanner port. a same-cycle APB write wins and is forwarded.
    always_ff @(posedge clk) begin
        if (wr_en && hit_table)
            table_mem[word_addr[IDX_W+1:0]] <= pwdata;
        if (wr_en && hit_table && word_addr[IDX_W+1:0] == tbl_addr)
            tbl_word <= pwdata;
        else
            tbl_word <= table_mem[tbl_addr];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ctrl_q <= '0;
        else if (wr_en && hit_ctrl)
            ctrl_q <= pwdata;
    end

    assign ctrl_enable = ctrl_q.enable;
    assign ctrl_line   = ctrl_q.line;

    always_comb begin
        status        = '0;
        status.busy   = scan_busy;
        status.count  = issue_count;
        prdata        = '0;  // unmapped reads return zero.
        if (hit_ctrl)
            prdata = ctrl_q;
        else if (hit_status)
            prdata = status;
        else if (hit_table)
            prdata = table_mem[word_addr[IDX_W+1:0]];
    end

endmodule

`default_nettype wire

// ==== obj_line_scan.sv ====
// walks the object table once per line and hands in-range sprites to the draw engine.
// the next entry is read while the current sprite is drawn.
`timescale 1ns/100ps
`default_nettype none
`include "obj_config.svh"

module obj_line_scan
    import obj_video_pkg::*;
    import obj_host_pkg::*;
(
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  line_start,
    input  wire                                  ctrl_enable,
    input  wire  [8:0]                           ctrl_line,
    output logic [$clog2(`OBJ_TABLE_DEPTH)-1:0]  tbl_index,
    output obj_entry_field_t                     tbl_field,
    input  wire  [31:0]                          tbl_word,
    output logic [15:0]                          obj_code,
    output logic [15:0]                          obj_attr,
    output logic [8:0]                           obj_hpos,
    output logic [1:0]                           obj_bank,
    output logic                                 start,
    input  wire                                  idle,
    output logic                                 scan_busy,
    output logic [5:0]                           issue_count
);

    localparam int IDX_W = $clog2(`OBJ_TABLE_DEPTH);

    obj_scan_state_t state;
    logic [2:0]      step;  // table word in flight.
    logic [8:0]      line_q;
    logic [15:0]     ent_code;
    obj_attr_t       ent_attr, issue_attr;
    logic [8:0]      ent_xpos;
    obj_ypos_bank_t  ent_yb;
    logic [8:0]      dy;
    logic            in_range, issue, advance;

    assign dy       = line_q - ent_yb.ypos;  // wraps mod 512.
    assign in_range = dy < `OBJ_TILE_H;
    assign issue    = state == SCAN_ISSUE && idle;
    assign advance  = issue || (state == SCAN_TEST && !in_range);

    always_comb begin
        issue_attr     = ent_attr;
        issue_attr.row = ent_attr.vflip ? ~dy[3:0] : dy[3:0];  // 15 - dy.
    end

    // ypos_bank first, then code, attr and xpos.
    always_comb begin
        case (step)
            3'd0:    tbl_field = FIELD_YPOS_BANK;
            3'd1:    tbl_field = FIELD_CODE;
            3'd2:    tbl_field = FIELD_ATTR;
            default: tbl_field = FIELD_XPOS;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= SCAN_IDLE;
            step        <= 3'd0;
            tbl_index   <= '0;
            line_q      <= 9'd0;
            scan_busy   <= 1'b0;
            issue_count <= 6'd0;
            start       <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                SCAN_IDLE: if (line_start && ctrl_enable) begin
                    scan_busy   <= 1'b1;
                    issue_count <= 6'd0;
                    line_q      <= ctrl_line;
                    tbl_index   <= IDX_W'(`OBJ_TABLE_DEPTH - 1);  // highest first.
                    step        <= 3'd0;
                    state       <= SCAN_READ;
                end
                SCAN_READ: begin
                    step <= step + 3'd1;
                    if (step == 3'd4)
                        state <= SCAN_TEST;
                end
                SCAN_TEST: if (in_range) state <= SCAN_ISSUE;
                SCAN_ISSUE: if (issue) begin
                    start       <= 1'b1;
                    issue_count <= issue_count + 6'd1;
                end
                SCAN_WAIT_DRAW: if (idle && !start) begin  // idle is stale while start is high.
                    scan_busy <= 1'b0;
                    state     <= SCAN_IDLE;
                end
                default: state <= SCAN_IDLE;
            endcase
            if (advance) begin
                step <= 3'd0;
                if (tbl_index == '0) begin
                    state <= SCAN_WAIT_DRAW;
                end else begin
                    tbl_index <= tbl_index - 1'b1;
                    state     <= SCAN_READ;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCAN_READ) begin
            case (step)
                3'd1:    ent_yb   <= tbl_word;
                3'd2:    ent_code <= tbl_word[15:0];
                3'd3:    ent_attr <= tbl_word[15:0];
                3'd4:    ent_xpos <= tbl_word[8:0];
                default: ;
            endcase
        end
        if (issue) begin  // held until the next issue.
            obj_code <= ent_code;
            obj_attr <= issue_attr;
            obj_hpos <= ent_xpos;
            obj_bank <= ent_yb.bank;
        end
    end

endmodule

`default_nettype wire

// ==== obj_draw.sv ====
// draw engine. fetches the two graphics words of a tile row and paints 16 pixels.
// all-ones words are skipped without writes.
`timescale 1ns/100ps
`default_nettype none
`include "obj_config.svh"

module obj_draw
    import obj_video_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire  [15:0] obj_code,
    input  wire  [15:0] obj_attr,
    input  wire  [8:0]  obj_hpos,
    input  wire  [1:0]  obj_bank,
    input  wire         start,
    output logic        idle,
    output logic [8:0]  buf_addr,
    output logic [8:0]  buf_data,
    output logic        buf_wr,
    output logic [19:0] rom_addr,
    output logic [1:0]  rom_bank,
    output logic        rom_half,
    input  wire  [31:0] rom_data,
    output logic        rom_cs,
    input  wire         rom_ok
);

    obj_draw_state_t state;
    obj_attr_t       attr;
    obj_pixel_t      pixel;
    logic [1:0]      wait_cycle;  // rom_ok holdoff after a word.
    logic            last_word;
    logic [2:0]      draw_cnt;
    logic [31:0]     pxl_data;
    logic [8:0]      x_ptr;
    logic            hflip_q;
    logic [4:0]      pal_q;
    logic            accept, rom_good, blank;

    // one pixel from the four byte lanes.
    function automatic logic [3:0] plane_pixel(input logic [31:0] w, input logic flip);
        if (flip)
            return {w[24], w[16], w[8], w[0]};
        return {w[31], w[23], w[15], w[7]};
    endfunction

    assign attr     = obj_attr;
    assign idle     = state == DRAW_IDLE;
    assign accept   = idle && start && obj_hpos > `OBJ_X_MIN && obj_hpos < `OBJ_X_MAX;
    assign rom_good = state == DRAW_FETCH && rom_ok && wait_cycle == 2'b00;
    assign blank    = &rom_data;

    always_comb begin
        pixel.pal    = pal_q;
        pixel.colour = plane_pixel(pxl_data, hflip_q);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= DRAW_IDLE;
            rom_cs     <= 1'b0;
            buf_wr     <= 1'b0;
            wait_cycle <= 2'b00;
            last_word  <= 1'b0;
            draw_cnt   <= 3'd0;
        end else begin
            wait_cycle <= wait_cycle >> 1;
            buf_wr     <= 1'b0;
            case (state)
                DRAW_IDLE: if (accept) begin
                    state      <= DRAW_FETCH;
                    rom_cs     <= 1'b1;
                    wait_cycle <= 2'b11;
                    last_word  <= 1'b0;
                end
                DRAW_FETCH: if (rom_good) begin
                    wait_cycle <= 2'b11;
                    if (last_word)
                        rom_cs <= 1'b0;
                    if (!blank) begin
                        state    <= DRAW_PAINT;
                        draw_cnt <= 3'd7;
                    end else if (last_word) begin
                        state <= DRAW_IDLE;
                    end else begin
                        last_word <= 1'b1;
                    end
                end
                DRAW_PAINT: begin
                    buf_wr   <= 1'b1;
                    draw_cnt <= draw_cnt - 3'd1;
                    if (draw_cnt == 3'd0) begin
                        state     <= last_word ? DRAW_IDLE : DRAW_FETCH;
                        last_word <= 1'b1;
                    end
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rom_addr <= {obj_code, attr.row};
            rom_bank <= obj_bank;
            rom_half <= attr.hflip;  // flipped tiles start on the other half.
            hflip_q  <= attr.hflip;
            pal_q    <= attr.pal;
            x_ptr    <= obj_hpos;
        end
        if (rom_good) begin
            pxl_data <= rom_data;
            if (!last_word)
                rom_half <= ~rom_half;  // request the second word early.
            if (blank)
                x_ptr <= x_ptr + 9'd8;
        end
        if (state == DRAW_PAINT) begin
            buf_addr <= x_ptr;
            buf_data <= pixel;
            x_ptr    <= x_ptr + 9'd1;
            pxl_data <= hflip_q ? {1'b1, pxl_data[31:1]} : {pxl_data[30:0], 1'b1};
        end
    end

endmodule

`default_nettype wire

// ==== obj_line_buf.sv ====
// double-buffered line buffer. one half is painted while the video side reads
// the other, and each read clears the entry it returns.
`timescale 1ns/100ps
`default_nettype none
`include "obj_config.svh"

module obj_line_buf
    import obj_video_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        line_start,
    input  wire        buf_wr,
    input  wire  [8:0] buf_addr,
    input  wire  [8:0] buf_data,
    input  wire        pix_rd,
    input  wire  [8:0] pix_addr,
    output logic [8:0] pix_data
);

    obj_pixel_t mem [2][`OBJ_LINE_W];
    obj_pixel_t wr_pix;
    logic       sel;   // half being painted.
    logic       disp;

    assign wr_pix = buf_data;
    assign disp   = ~sel;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sel <= 1'b0;
        else if (line_start)
            sel <= ~sel;
    end

    always_ff @(posedge clk) begin
        if (buf_wr && wr_pix.colour != 4'hf)  // transparent pixels keep what is there.
            mem[sel][buf_addr] <= wr_pix;
        if (pix_rd) begin
            pix_data            <= mem[disp][pix_addr];
            mem[disp][pix_addr] <= `OBJ_BLANK_PIXEL;
        end
    end

endmodule

`default_nettype wire

// ==== obj_engine_top.sv ====
// object engine top level. APB host registers, table scanner, draw engine and
// line buffer; the graphics ROM sits outside.
`timescale 1ns/100ps
`default_nettype none

module obj_engine_top
    import obj_host_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [11:0] paddr,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  wire         line_start,
    input  wire         pix_rd,
    input  wire  [8:0]  pix_addr,
    output logic [8:0]  pix_data,
    output logic [19:0] rom_addr,
    output logic [1:0]  rom_bank,
    output logic        rom_half,
    input  wire  [31:0] rom_data,
    output logic        rom_cs,
    input  wire         rom_ok,
    output logic        busy
);

    logic [4:0]       tbl_index;
    obj_entry_field_t tbl_field;
    logic [31:0]      tbl_word;
    logic             ctrl_enable;
    logic [8:0]       ctrl_line;
    logic [5:0]       issue_count;
    logic [15:0]      obj_code, obj_attr;
    logic [8:0]       obj_hpos;
    logic [1:0]       obj_bank;
    logic             start, idle;
    logic [8:0]       buf_addr, buf_data;
    logic             buf_wr;

    obj_host_regs obj_host_regs_inst (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .tbl_index(tbl_index), .tbl_field(tbl_field), .tbl_word(tbl_word),
        .ctrl_enable(ctrl_enable), .ctrl_line(ctrl_line),
        .scan_busy(busy), .issue_count(issue_count)
    );

    obj_line_scan obj_line_scan_inst (
        .clk(clk), .rst(rst), .line_start(line_start),
        .ctrl_enable(ctrl_enable), .ctrl_line(ctrl_line),
        .tbl_index(tbl_index), .tbl_field(tbl_field), .tbl_word(tbl_word),
        .obj_code(obj_code), .obj_attr(obj_attr), .obj_hpos(obj_hpos), .obj_bank(obj_bank),
        .start(start), .idle(idle), .scan_busy(busy), .issue_count(issue_count)
    );

    obj_draw obj_draw_inst (
        .clk(clk), .rst(rst),
        .obj_code(obj_code), .obj_attr(obj_attr), .obj_hpos(obj_hpos), .obj_bank(obj_bank),
        .start(start), .idle(idle),
        .buf_addr(buf_addr), .buf_data(buf_data), .buf_wr(buf_wr),
        .rom_addr(rom_addr), .rom_bank(rom_bank), .rom_half(rom_half),
        .rom_data(rom_data), .rom_cs(rom_cs), .rom_ok(rom_ok)
    );

    obj_line_buf obj_line_buf_inst (
        .clk(clk), .rst(rst), .line_start(line_start),
        .buf_wr(buf_wr), .buf_addr(buf_addr), .buf_data(buf_data),
        .pix_rd(pix_rd), .pix_addr(pix_addr), .pix_data(pix_data)
    );

endmodule

`default_nettype wire

// ==== tb_gfx_rom.sv ====
// graphics ROM model for the object engine testbench.
// words are a hash of bank, half and address; rom_ok follows a new address by two cycles.
`timescale 1ns/100ps
`default_nettype none

module tb_gfx_rom (
    input  wire         clk,
    input  wire         rst,
    input  wire         rom_cs,
    input  wire  [19:0] rom_addr,
    input  wire  [1:0]  rom_bank,
    input  wire         rom_half,
    output logic [31:0] rom_data,
    output logic        rom_ok
);

    logic [22:0] key, key_q;
    logic [1:0]  age;  // cycles the current address has been held.

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] hash_word(input logic [22:0] k);
        logic [31:0] h;
        h = lcg_next(32'h1d1b_75aa ^ {9'd0, k});
        h = lcg_next(h ^ (h >> 13));
        h = h ^ (h >> 16);
        return (h[2:0] == 3'd0) ? 32'hffff_ffff : h;  // one word in eight is blank.
    endfunction

    assign key      = {rom_bank, rom_half, rom_addr};
    assign rom_data = hash_word(key);
    assign rom_ok   = rom_cs && key == key_q && age == 2'd2;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_q <= '0;
            age   <= 2'd0;
        end else if (!rom_cs) begin
            age <= 2'd0;
        end else if (key != key_q) begin
            key_q <= key;  // new request, restart the latency.
            age   <= 2'd1;
        end else if (age != 2'd2) begin
            age <= age + 2'd1;
        end
    end

endmodule

`default_nettype wire

// ==== obj_engine_tb.sv ====
// testbench for the object engine. loads sprite tables over APB, draws one line per
// table row and compares the whole line buffer with a reference model.
`timescale 1ns/100ps
`default_nettype none
`include "obj_config.svh"

module obj_engine_tb
    import obj_host_pkg::*;
();

    localparam int NUM_ROWS = 6;
    localparam int MAX_SPR  = 5;
    localparam int LIMIT    = NUM_ROWS * 2000;  // cycles.

    typedef struct packed {
        logic [4:0]  idx;
        logic [1:0]  bank;
        logic [15:0] code;
        logic        vflip;
        logic        hflip;
        logic [4:0]  pal;
        logic [8:0]  x;
        logic [8:0]  y;
    } sprite_t;

    logic        clk, rst;
    logic        psel, penable, pwrite, pready, pslverr;
    logic [11:0] paddr;
    logic [31:0] pwdata, prdata, rom_data;
    logic        line_start, pix_rd, busy, rom_half, rom_cs, rom_ok;
    logic [8:0]  pix_addr, pix_data;
    logic [19:0] rom_addr;
    logic [1:0]  rom_bank;

    string       row_name  [NUM_ROWS];
    int          row_line  [NUM_ROWS];
    int          row_count [NUM_ROWS];
    sprite_t     row_spr   [NUM_ROWS][MAX_SPR];
    logic [31:0] tbl [4 * `OBJ_TABLE_DEPTH];  // table image as written.
    logic [8:0]  expect_line [`OBJ_LINE_W];
    logic [8:0]  got_line [`OBJ_LINE_W];
    int          n_rows, errors, checks, cycle_cnt;

    obj_engine_top obj_engine_top_inst (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .line_start(line_start), .pix_rd(pix_rd), .pix_addr(pix_addr), .pix_data(pix_data),
        .rom_addr(rom_addr), .rom_bank(rom_bank), .rom_half(rom_half),
        .rom_data(rom_data), .rom_cs(rom_cs), .rom_ok(rom_ok), .busy(busy)
    );

    tb_gfx_rom tb_gfx_rom_inst (
        .clk(clk), .rst(rst), .rom_cs(rom_cs), .rom_addr(rom_addr),
        .rom_bank(rom_bank), .rom_half(rom_half), .rom_data(rom_data), .rom_ok(rom_ok)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout, the run did not finish within %0d cycles", LIMIT);
        $display("Test failures found");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // graphics word the ROM holds for one bank, half and address.
    function automatic logic [31:0] expected_rom_word(input logic [1:0] bank,
                                                      input logic half,
                                                      input logic [19:0] addr);
        logic [31:0] h;
        h = lcg_next(32'h1d1b_75aa ^ {9'd0, bank, half, addr});
        h = lcg_next(h ^ (h >> 13));
        h = h ^ (h >> 16);
        return (h[2:0] == 3'd0) ? 32'hffff_ffff : h;
    endfunction

    function automatic logic [11:0] table_addr(input int w);
        return {REG_TABLE + 10'(w), 2'b00};
    endfunction

    task automatic new_row(input string name, input int line);
        row_name[n_rows]  = name;
        row_line[n_rows]  = line;
        row_count[n_rows] = 0;
        n_rows++;
    endtask

    task automatic add_sprite(input sprite_t s);
        row_spr[n_rows - 1][row_count[n_rows - 1]] = s;
        row_count[n_rows - 1]++;
    endtask

    // idx, bank, code, vflip, hflip, pal, x, y.
    task automatic fill_rows();
        n_rows = 0;
        new_row("single", 100);
        add_sprite(sprite_t'{5'd3, 2'd1, 16'h0123, 1'b0, 1'b0, 5'd5, 9'h080, 9'd95});
        new_row("flip", 40);
        add_sprite(sprite_t'{5'd10, 2'd2, 16'h0456, 1'b0, 1'b1, 5'd9, 9'h060, 9'd30});
        add_sprite(sprite_t'{5'd11, 2'd0, 16'h0789, 1'b1, 1'b0, 5'd12, 9'h100, 9'd38});
        add_sprite(sprite_t'{5'd12, 2'd3, 16'h0abc, 1'b1, 1'b1, 5'd3, 9'h150, 9'd27});
        new_row("overlap", 200);
        add_sprite(sprite_t'{5'd2, 2'd0, 16'h0111, 1'b0, 1'b0, 5'd1, 9'h090, 9'd190});
        add_sprite(sprite_t'{5'd7, 2'd1, 16'h0222, 1'b0, 1'b0, 5'd2, 9'h094, 9'd195});
        add_sprite(sprite_t'{5'd20, 2'd2, 16'h0333, 1'b0, 1'b1, 5'd4, 9'h098, 9'd200});
        new_row("reject", 300);
        add_sprite(sprite_t'{5'd0, 2'd0, 16'h0010, 1'b0, 1'b0, 5'd6, 9'h030, 9'd295});
        add_sprite(sprite_t'{5'd1, 2'd1, 16'h0020, 1'b0, 1'b0, 5'd7, 9'h1c0, 9'd290});
        add_sprite(sprite_t'{5'd5, 2'd2, 16'h0030, 1'b0, 1'b0, 5'd8, 9'h100, 9'd320});
        add_sprite(sprite_t'{5'd6, 2'd3, 16'h0040, 1'b0, 1'b0, 5'd9, 9'h120, 9'd280});
        add_sprite(sprite_t'{5'd8, 2'd0, 16'h0050, 1'b0, 1'b0, 5'd10, 9'h031, 9'd300});
        new_row("wrap", 3);  // y ranges that cross line 511.
        add_sprite(sprite_t'{5'd31, 2'd1, 16'h0666, 1'b0, 1'b0, 5'd11, 9'h1bf, 9'd500});
        add_sprite(sprite_t'{5'd30, 2'd2, 16'h0777, 1'b1, 1'b0, 5'd13, 9'h040, 9'd507});
        new_row("empty", 50);
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, addr, data, rd, err);
    endtask

    task automatic pulse_line_start();
        line_start = 1'b1;
        @(posedge clk);
        #1 line_start = 1'b0;
    endtask

    // reads the display half; every read also clears the entry.
    task automatic read_line();
        int a;
        for (a = 0; a < `OBJ_LINE_W; a++) begin
            pix_rd   = 1'b1;
            pix_addr = 9'(a);
            @(posedge clk);
            #1 got_line[a] = pix_data;
        end
        pix_rd = 1'b0;
    endtask

    task automatic load_row(input int r);
        sprite_t s;
        int      e, n;
        for (e = 0; e < 4 * `OBJ_TABLE_DEPTH; e++)
            tbl[e] = 32'h0;
        for (e = 0; e < `OBJ_TABLE_DEPTH; e++)  // unused entries half a frame away.
            tbl[4 * e + int'(FIELD_YPOS_BANK)] = {23'd0, 9'(row_line[r] + 256)};
        for (n = 0; n < row_count[r]; n++) begin
            s = row_spr[r][n];
            tbl[4 * s.idx + int'(FIELD_CODE)]      = {16'd0, s.code};
            tbl[4 * s.idx + int'(FIELD_ATTR)]      = {25'd0, s.vflip, s.hflip, s.pal};
            tbl[4 * s.idx + int'(FIELD_XPOS)]      = {23'd0, s.x};
            tbl[4 * s.idx + int'(FIELD_YPOS_BANK)] = {14'd0, s.bank, 7'd0, s.y};
        end
        for (e = 0; e < 4 * `OBJ_TABLE_DEPTH; e++)
            apb_write(table_addr(e), tbl[e]);
    endtask

    // paints the row highest index first, so low indices end up on top.
    task automatic build_model(input int r, output int count);
        sprite_t     s;
        logic [8:0]  dy;
        logic [3:0]  row, colour;
        logic [31:0] w;
        int          a, i, n, k, j;
        count = 0;
        for (a = 0; a < `OBJ_LINE_W; a++)
            expect_line[a] = `OBJ_BLANK_PIXEL;
        for (i = `OBJ_TABLE_DEPTH - 1; i >= 0; i--) begin
            for (n = 0; n < row_count[r]; n++) begin
                s  = row_spr[r][n];
                dy = 9'(row_line[r]) - s.y;
                if (s.idx != 5'(i) || dy >= `OBJ_TILE_H)
                    continue;
                count++;
                if (s.x <= `OBJ_X_MIN || s.x >= `OBJ_X_MAX)
                    continue;
                row = s.vflip ? 4'(15 - dy) : dy[3:0];
                for (k = 0; k < 16; k++) begin
                    w = expected_rom_word(s.bank, s.hflip ^ (k >= 8), {s.code, row});
                    j = k % 8;
                    if (s.hflip)
                        colour = {w[24 + j], w[16 + j], w[8 + j], w[j]};
                    else
                        colour = {w[31 - j], w[23 - j], w[15 - j], w[7 - j]};
                    if (colour != 4'hf)  // transparent.
                        expect_line[s.x + 9'(k)] = {s.pal, colour};
                end
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    initial begin
        int          r, a, count, w;
        logic [31:0] rd, ctrl_word;
        logic        err;
        errors     = 0;
        checks     = 0;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        line_start = 1'b0;
        pix_rd     = 1'b0;
        pix_addr   = '0;
        fill_rows();
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
        check_value("reset busy", 0, busy);
        check_value("reset rom_cs", 0, rom_cs);
        check_value("reset pslverr", 0, pslverr);
        check_value("pready", 1, pready);

        // both halves hold unknown data after reset and are drained first.
        read_line();
        pulse_line_start();
        read_line();

        apb_xfer(1'b0, 12'h008, 32'h0, rd, err);
        check_value("unmapped read pslverr", 1, err);
        apb_xfer(1'b1, 12'h400, 32'hdead_beef, rd, err);
        check_value("unmapped write pslverr", 1, err);
        apb_xfer(1'b0, {REG_CTRL, 2'b00}, 32'h0, rd, err);
        check_value("unmapped write ignored", 0, rd);
        apb_xfer(1'b0, {REG_STATUS, 2'b00}, 32'h0, rd, err);
        check_value("status pslverr", 0, err);

        for (r = 0; r < n_rows; r++) begin
            load_row(r);
            w = (r * 37 + 3) % (4 * `OBJ_TABLE_DEPTH);
            apb_xfer(1'b0, table_addr(w), 32'h0, rd, err);
            check_value({row_name[r], " table readback"}, tbl[w], rd);
            ctrl_word = {7'd0, 9'(row_line[r]), 15'd0, 1'b1};
            apb_write({REG_CTRL, 2'b00}, ctrl_word);
            apb_xfer(1'b0, {REG_CTRL, 2'b00}, 32'h0, rd, err);
            check_value({row_name[r], " ctrl readback"}, ctrl_word, rd);

            pulse_line_start();
            check_value({row_name[r], " busy rise"}, 1, busy);
            while (busy) begin
                @(posedge clk);
                #1;
            end
            build_model(r, count);
            apb_xfer(1'b0, {REG_STATUS, 2'b00}, 32'h0, rd, err);
            check_value({row_name[r], " status"}, {18'd0, 6'(count), 7'd0, 1'b0}, rd);

            // scanner disabled so the swap starts no second line.
            apb_write({REG_CTRL, 2'b00}, ctrl_word & ~32'h1);
            pulse_line_start();
            read_line();
            for (a = 0; a < `OBJ_LINE_W; a++)
                check_value($sformatf("%s pixel %0d", row_name[r], a),
                            expect_line[a], got_line[a]);
        end

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
obj_video_pkg.sv
obj_host_pkg.sv
obj_host_regs.sv
obj_line_scan.sv
obj_draw.sv
obj_line_buf.sv
obj_engine_top.sv
tb_gfx_rom.sv
obj_engine_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the object engine testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module obj_engine_tb -o obj_engine_sim

./obj_dir/obj_engine_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi

echo "simulation passed"
exit 0
